// File: hub75_driver.f
logic/hub75_pkg.sv
logic/uart_rx.sv
logic/command_decoder.sv
logic/framebuffer.sv
logic/matrix_scan.sv
logic/bitplane_select.sv
logic/hub75_top.sv
tb/hub75_properties.sv
tb/hub75_tb.sv

// File: logic/bitplane_select.sv
// bitplane stage between the framebuffer and the panel pins
// reads the pixel pair, picks the plane bit, masks it, registers the port
`timescale 1ns/10ps
module bitplane_select import hub75_pkg::*; (
    input  logic                   clk_in,
    input  logic                   rst_n,
    input  scan_ctrl_t             scan,
    input  display_cfg_t           display_cfg,
    output logic [ROW_BITS-1:0]    read_row,
    output logic [COLUMN_BITS-1:0] read_column,
    input  pixel_t                 pixel_top,
    input  pixel_t                 pixel_bottom,
    output panel_port_t            panel
);

    scan_ctrl_t scan_d1; // lines up with the ram output

    // one channel bit per plane, gated by both masks
    function automatic rgb_t plane_bits(input pixel_t px, input logic [PLANE_BITS-1:0] plane,
                                        input display_cfg_t cfg);
        rgb_t bits;
        logic plane_on;
        plane_on = cfg.brightness_enable[plane];
        bits.r   = px.r[plane] & plane_on & cfg.rgb_enable.r;
        bits.g   = px.g[plane] & plane_on & cfg.rgb_enable.g;
        bits.b   = px.b[plane] & plane_on & cfg.rgb_enable.b;
        return bits;
    endfunction

    assign read_row    = scan.row;
    assign read_column = scan.column;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            scan_d1 <= '0;
        end else begin
            scan_d1 <= scan;
        end
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            panel.rgb_top         <= '0;
            panel.rgb_bottom      <= '0;
            panel.row_address     <= '0;
            panel.clk_pixel       <= 1'b0;
            panel.row_latch       <= 1'b0;
            panel.output_enable_n <= 1'b1; // panel dark
        end else begin
            panel.rgb_top         <= plane_bits(pixel_top, scan_d1.plane, display_cfg);
            panel.rgb_bottom      <= plane_bits(pixel_bottom, scan_d1.plane, display_cfg);
            panel.clk_pixel       <= scan_d1.load;
            panel.row_latch       <= scan_d1.latch;
            panel.output_enable_n <= ~scan_d1.oe;
            if (scan_d1.latch) panel.row_address <= scan_d1.row; // held until next latch
        end
    end

endmodule

// File: logic/command_decoder.sv
// command decoder for the serial write path
// turns opcode and argument bytes into pixel writes and display masks
`timescale 1ns/10ps
module command_decoder import hub75_pkg::*; (
    input  logic         clk_in,
    input  logic         rst_n,
    input  rx_byte_t     rx_byte,
    output fb_write_t    fb_write,
    output display_cfg_t display_cfg
);

    cmd_state_e             state;
    cmd_opcode_e            mask_op; // which mask command is pending
    logic [COLUMN_BITS-1:0] x_reg;
    logic                   bank_reg;
    logic [ROW_BITS-1:0]    row_reg;
    logic [7:0]             rg_reg;
    logic [3:0]             b_reg;
    logic                   write_strobe;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state        <= CMD_IDLE;
            mask_op      <= CMD_BRIGHTNESS;
            write_strobe <= 1'b0;
            display_cfg  <= '{brightness_enable: '1, rgb_enable: '1};
        end else begin
            write_strobe <= 1'b0;
            if (rx_byte.valid) begin
                case (state)
                    CMD_IDLE: begin
                        case (cmd_opcode_e'(rx_byte.data))
                            CMD_PIXEL: state <= CMD_X;
                            CMD_BRIGHTNESS, CMD_RGB_ENABLE: begin
                                mask_op <= cmd_opcode_e'(rx_byte.data);
                                state   <= CMD_MASK;
                            end
                            default: state <= CMD_IDLE; // unknown opcode
                        endcase
                    end
                    CMD_X:  state <= CMD_Y;
                    CMD_Y:  state <= CMD_RG;
                    CMD_RG: state <= CMD_B;
                    CMD_B: begin
                        write_strobe <= 1'b1; // last pixel byte
                        state        <= CMD_IDLE;
                    end
                    CMD_MASK: begin
                        if (mask_op == CMD_BRIGHTNESS) begin
                            display_cfg.brightness_enable <= rx_byte.data[PLANE_COUNT-1:0];
                        end else begin
                            display_cfg.rgb_enable <= rx_byte.data[2:0]; // r is bit 2
                        end
                        state <= CMD_IDLE;
                    end
                    default: state <= CMD_IDLE;
                endcase
            end
        end
    end

    // argument capture
    always_ff @(posedge clk_in) begin
        if (rx_byte.valid) begin
            case (state)
                CMD_X: x_reg <= rx_byte.data[COLUMN_BITS-1:0];
                CMD_Y: begin
                    bank_reg <= rx_byte.data[ROW_BITS]; // y >= 8 is the bottom half
                    row_reg  <= rx_byte.data[ROW_BITS-1:0];
                end
                CMD_RG:  rg_reg <= rx_byte.data;
                CMD_B:   b_reg  <= rx_byte.data[3:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        fb_write.bank    = bank_reg;
        fb_write.row     = row_reg;
        fb_write.column  = x_reg;
        fb_write.pixel.r = rg_reg[7:4];
        fb_write.pixel.g = rg_reg[3:0];
        fb_write.pixel.b = b_reg;
        fb_write.write   = write_strobe;
    end

endmodule

// File: logic/framebuffer.sv
// two-bank pixel memory, top half and bottom half of the panel
// one write port, both banks read at one address with registered output
`timescale 1ns/10ps
module framebuffer import hub75_pkg::*; (
    input  logic                   clk_in,
    input  fb_write_t              fb_write,
    input  logic [ROW_BITS-1:0]    read_row,
    input  logic [COLUMN_BITS-1:0] read_column,
    output pixel_t                 pixel_top,
    output pixel_t                 pixel_bottom
);

    pixel_t mem_top    [PANEL_HALF_HEIGHT * PANEL_WIDTH];
    pixel_t mem_bottom [PANEL_HALF_HEIGHT * PANEL_WIDTH];

    logic [ROW_BITS+COLUMN_BITS-1:0] write_addr;
    logic [ROW_BITS+COLUMN_BITS-1:0] read_addr;

    assign write_addr = {fb_write.row, fb_write.column};
    assign read_addr  = {read_row, read_column};

    always_ff @(posedge clk_in) begin
        if (fb_write.write && !fb_write.bank) begin
            mem_top[write_addr] <= fb_write.pixel;
        end
        if (fb_write.write && fb_write.bank) begin
            mem_bottom[write_addr] <= fb_write.pixel;
        end
    end

    always_ff @(posedge clk_in) begin
        pixel_top    <= mem_top[read_addr];
        pixel_bottom <= mem_bottom[read_addr];
    end

endmodule

// File: logic/hub75_pkg.sv
// hub75 panel driver shared definitions
// panel geometry, uart timing, bus structs and state encodings
package hub75_pkg;

    // panel geometry
    localparam int PANEL_WIDTH       = 32;
    localparam int PANEL_HEIGHT      = 16;
    localparam int PANEL_HALF_HEIGHT = PANEL_HEIGHT / 2;
    localparam int COLUMN_BITS       = 5;
    localparam int ROW_BITS          = 3;
    localparam int PLANE_COUNT       = 4;
    localparam int PLANE_BITS        = $clog2(PLANE_COUNT);

    localparam int UART_TICKS_PER_BIT = 8;
    localparam int UART_TICK_BITS     = $clog2(UART_TICKS_PER_BIT);

    localparam int DISPLAY_BASE_TICKS = 4; // oe cycles for plane 0
    localparam int DISPLAY_TICK_BITS  = $clog2(DISPLAY_BASE_TICKS << (PLANE_COUNT - 1));

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } pixel_t; // rgb444

    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } rgb_t;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } rx_byte_t;

    typedef enum logic [7:0] {
        CMD_PIXEL      = 8'h50,
        CMD_BRIGHTNESS = 8'h42,
        CMD_RGB_ENABLE = 8'h45
    } cmd_opcode_e;

    typedef enum logic [2:0] {
        CMD_IDLE,
        CMD_X,
        CMD_Y,
        CMD_RG,
        CMD_B,
        CMD_MASK
    } cmd_state_e;

    typedef enum logic [1:0] {
        SCAN_SHIFT,
        SCAN_LATCH,
        SCAN_DISPLAY
    } scan_state_e;

    typedef struct packed {
        logic                   bank; // bottom half when set
        logic [ROW_BITS-1:0]    row;
        logic [COLUMN_BITS-1:0] column;
        pixel_t                 pixel;
        logic                   write;
    } fb_write_t;

    typedef struct packed {
        logic [PLANE_COUNT-1:0] brightness_enable;
        rgb_t                   rgb_enable;
    } display_cfg_t;

    typedef struct packed {
        logic [COLUMN_BITS-1:0] column;
        logic [ROW_BITS-1:0]    row;
        logic [PLANE_BITS-1:0]  plane;
        logic                   load;
        logic                   latch;
        logic                   oe;
    } scan_ctrl_t;

    typedef struct packed {
        rgb_t                rgb_top;
        rgb_t                rgb_bottom;
        logic [ROW_BITS-1:0] row_address;
        logic                clk_pixel;
        logic                row_latch;
        logic                output_enable_n;
    } panel_port_t;

endpackage

// File: logic/hub75_top.sv
// hub75 panel driver top level
// serial command path into the framebuffer, scan and bitplane stages to the pins
`timescale 1ns/10ps
module hub75_top import hub75_pkg::*; (
    input  logic        clk_in,
    input  logic        rst_n,
    input  logic        serial_rx, // idles high
    output panel_port_t panel
);

    rx_byte_t               rx_byte;
    fb_write_t              fb_write;
    display_cfg_t           display_cfg;
    scan_ctrl_t             scan;
    logic [ROW_BITS-1:0]    read_row;
    logic [COLUMN_BITS-1:0] read_column;
    pixel_t                 pixel_top;
    pixel_t                 pixel_bottom;

    uart_rx i_uart_rx (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .serial_rx (serial_rx),
        .rx_byte   (rx_byte)
    );

    command_decoder i_command_decoder (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .rx_byte     (rx_byte),
        .fb_write    (fb_write),
        .display_cfg (display_cfg)
    );

    framebuffer i_framebuffer (
        .clk_in       (clk_in),
        .fb_write     (fb_write),
        .read_row     (read_row),
        .read_column  (read_column),
        .pixel_top    (pixel_top),
        .pixel_bottom (pixel_bottom)
    );

    matrix_scan i_matrix_scan (
        .clk_in (clk_in),
        .rst_n  (rst_n),
        .scan   (scan)
    );

    // two cycles from scan step to pins
    bitplane_select i_bitplane_select (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .scan         (scan),
        .display_cfg  (display_cfg),
        .read_row     (read_row),
        .read_column  (read_column),
        .pixel_top    (pixel_top),
        .pixel_bottom (pixel_bottom),
        .panel        (panel)
    );

endmodule

// File: logic/matrix_scan.sv
// scan timing for the panel
// shifts a row, latches it, then holds oe for a binary-weighted time per plane
`timescale 1ns/10ps
module matrix_scan import hub75_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_n,
    output scan_ctrl_t scan
);

    scan_state_e              state;
    logic [COLUMN_BITS-1:0]   column_count;
    logic [ROW_BITS-1:0]      row_count;
    logic [PLANE_BITS-1:0]    plane_count;
    logic [DISPLAY_TICK_BITS-1:0] display_tick;
    logic                     phase; // load on phase 0, advance on phase 1
    logic                     last_column;
    logic                     display_done;

    assign last_column  = (column_count == COLUMN_BITS'(PANEL_WIDTH - 1));
    assign display_done =
        (display_tick == DISPLAY_TICK_BITS'((DISPLAY_BASE_TICKS << plane_count) - 1));

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state        <= SCAN_SHIFT;
            column_count <= '0;
            row_count    <= '0;
            plane_count  <= '0;
            display_tick <= '0;
            phase        <= 1'b0;
        end else begin
            case (state)
                SCAN_SHIFT: begin
                    phase <= ~phase;
                    if (phase) begin
                        if (last_column) begin
                            column_count <= '0;
                            state        <= SCAN_LATCH;
                        end else begin
                            column_count <= column_count + 1'b1;
                        end
                    end
                end
                SCAN_LATCH: begin
                    display_tick <= '0;
                    state        <= SCAN_DISPLAY;
                end
                SCAN_DISPLAY: begin
                    display_tick <= display_tick + 1'b1;
                    if (display_done) begin
                        state <= SCAN_SHIFT;
                        phase <= 1'b0;
                        // planes first, then rows
                        if (plane_count == PLANE_BITS'(PLANE_COUNT - 1)) begin
                            plane_count <= '0;
                            if (row_count == ROW_BITS'(PANEL_HALF_HEIGHT - 1)) begin
                                row_count <= '0;
                            end else begin
                                row_count <= row_count + 1'b1;
                            end
                        end else begin
                            plane_count <= plane_count + 1'b1;
                        end
                    end
                end
                default: state <= SCAN_SHIFT;
            endcase
        end
    end

    always_comb begin
        scan.column = column_count;
        scan.row    = row_count;
        scan.plane  = plane_count;
        scan.load   = (state == SCAN_SHIFT) && !phase;
        scan.latch  = (state == SCAN_LATCH);
        scan.oe     = (state == SCAN_DISPLAY);
    end

endmodule

// File: logic/uart_rx.sv
// uart receiver, 8N1, lsb first
// two-flop input synchronizer and mid-bit sampling
`timescale 1ns/10ps
module uart_rx import hub75_pkg::*; (
    input  logic     clk_in,
    input  logic     rst_n,
    input  logic     serial_rx,
    output rx_byte_t rx_byte
);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP,
        RX_FINISH
    } rx_state_e;

    rx_state_e                 state;
    logic [1:0]                sync_ff;
    logic                      rx_bit;
    logic [UART_TICK_BITS-1:0] tick;
    logic [2:0]                bit_index;
    logic [7:0]                shift_reg;
    logic                      valid_q;
    logic                      half_bit;
    logic                      full_bit;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            sync_ff <= 2'b11; // line idles high
        end else begin
            sync_ff <= {sync_ff[0], serial_rx};
        end
    end

    assign rx_bit   = sync_ff[1];
    assign half_bit = (tick == UART_TICK_BITS'(UART_TICKS_PER_BIT / 2 - 1));
    assign full_bit = (tick == UART_TICK_BITS'(UART_TICKS_PER_BIT - 1));

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state     <= RX_IDLE;
            tick      <= '0;
            bit_index <= '0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            tick    <= tick + 1'b1;
            case (state)
                RX_IDLE: begin
                    tick      <= '0;
                    bit_index <= '0;
                    if (!rx_bit) state <= RX_START;
                end
                RX_START: if (half_bit) begin // middle of start bit
                    tick  <= '0;
                    state <= rx_bit ? RX_IDLE : RX_DATA; // glitch check
                end
                RX_DATA: if (full_bit) begin
                    tick      <= '0;
                    bit_index <= bit_index + 1'b1;
                    if (bit_index == 3'd7) state <= RX_STOP;
                end
                RX_STOP: if (full_bit) begin
                    tick    <= '0;
                    valid_q <= rx_bit; // bad stop bit drops the frame
                    state   <= rx_bit ? RX_IDLE : RX_FINISH;
                end
                // wait out the rest of a low stop bit
                RX_FINISH: if (tick == UART_TICK_BITS'(UART_TICKS_PER_BIT / 2 - 2)) begin
                    state <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == RX_DATA && full_bit) begin
            shift_reg <= {rx_bit, shift_reg[7:1]};
        end
    end

    assign rx_byte = '{data: shift_reg, valid: valid_q};

endmodule

// File: tb/hub75_properties.sv
// panel port protocol checks, bound into the hub75 top level
// pixel clock, latch and output enable must never overlap
`timescale 1ns/10ps
module hub75_properties import hub75_pkg::*; (
    input logic        clk_in,
    input logic        rst_n,
    input panel_port_t panel
);

    // pixel clock and row latch are separate strobes
    assert property (@(posedge clk_in) disable iff (!rst_n)
        !(panel.clk_pixel && panel.row_latch))
        else $error("clk_pixel and row_latch high in the same cycle");

    assert property (@(posedge clk_in) disable iff (!rst_n)
        panel.clk_pixel |-> panel.output_enable_n) // panel dark while shifting
        else $error("output_enable_n low during a clk_pixel pulse");

    assert property (@(posedge clk_in) disable iff (!rst_n)
        panel.clk_pixel |=> !panel.clk_pixel)
        else $error("clk_pixel high on two consecutive cycles");

    // sync reset, so outputs settle one edge after rst_n is seen low
    assert property (@(posedge clk_in)
        !rst_n |=> (panel.rgb_top == '0 && panel.rgb_bottom == '0 &&
                    !panel.clk_pixel && !panel.row_latch && panel.output_enable_n))
        else $error("panel outputs active during reset");

endmodule

bind hub75_top hub75_properties i_properties (
    .clk_in (clk_in),
    .rst_n  (rst_n),
    .panel  (panel)
);

// File: tb/hub75_tb.sv
// testbench for the hub75 panel driver
// sends uart bytes from the vector file, captures panel frames, checks pixels and scan
`timescale 1ns/10ps
module hub75_tb import hub75_pkg::*; ();

    logic        clk_in;
    logic        rst_n;
    logic        serial_rx;
    panel_port_t panel;

    logic [31:0] vectors [128]; // room for the vector file
    int          bytes_total;
    int          checks_total;
    int          vector_count;
    int          frame_cycles;
    int          cycle_limit = 0;
    int          cycle_count = 0;

    // monitor state
    rgb_t                line_top    [PANEL_WIDTH];
    rgb_t                line_bottom [PANEL_WIDTH];
    rgb_t                frame_top    [PANEL_HALF_HEIGHT][PLANE_COUNT][PANEL_WIDTH];
    rgb_t                frame_bottom [PANEL_HALF_HEIGHT][PLANE_COUNT][PANEL_WIDTH];
    int                  pulse_count = 0;
    int                  oe_cycles   = 0;
    int                  latch_count = 0;
    int                  last_plane  = 0;
    int                  frame_count = 0; // full frames captured
    logic [ROW_BITS-1:0] expected_row = '0;

    hub75_top i_dut (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .serial_rx (serial_rx),
        .panel     (panel)
    );

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    task automatic report_failure(input string message);
        $display("%s", message);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_rgb(input string name, input rgb_t actual, input rgb_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("ERR %s got %h expected %h", name, actual, expected));
        end
    endtask

    task automatic check_row(input string name, input logic [ROW_BITS-1:0] actual,
                             input logic [ROW_BITS-1:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("ERR %s got %h expected %h", name, actual, expected));
        end
    endtask

    task automatic check_cycles(input string name, input int actual, input int expected);
        if (actual != expected) begin
            report_failure($sformatf("ERR %s got %0h expected %0h", name, actual, expected));
        end
    endtask

    task automatic send_bit(input logic value);
        @(posedge clk_in);
        serial_rx <= value;
        repeat (UART_TICKS_PER_BIT - 1) @(posedge clk_in);
    endtask

    // 8N1 frame sent lsb first with one idle bit after it
    task automatic send_byte(input logic [7:0] data, input logic bad_stop);
        send_bit(1'b0);
        for (int i = 0; i < 8; i++) send_bit(data[i]);
        send_bit(!bad_stop);
        send_bit(1'b1);
    endtask

    // second latch of row 7 plane 3 ends a frame read wholly after the last write
    task automatic wait_fresh_frame();
        int target;
        target = frame_count + 2;
        while (frame_count < target) @(posedge clk_in);
    endtask

    task automatic check_pixel(input logic [31:0] rec);
        logic [ROW_BITS-1:0]    row;
        logic [PLANE_BITS-1:0]  plane;
        logic [COLUMN_BITS-1:0] column;
        string                  where;
        row    = rec[26:24];
        plane  = rec[21:20];
        column = rec[16:12];
        where  = $sformatf("row %0d plane %0d column %0d", row, plane, column);
        check_rgb({"rgb_top at ", where}, frame_top[row][plane][column], rgb_t'(rec[10:8]));
        check_rgb({"rgb_bottom at ", where}, frame_bottom[row][plane][column],
                  rgb_t'(rec[6:4]));
    endtask

    always @(posedge clk_in) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            report_failure($sformatf("timeout, run did not finish in %0d cycles", cycle_limit));
        end
    end

    // panel monitor sampled on the falling edge
    always @(negedge clk_in) begin : monitor
        int latch_plane;
        if (rst_n) begin
            if (!panel.output_enable_n) oe_cycles++;
            if (panel.clk_pixel) begin
                if (pulse_count < PANEL_WIDTH) begin
                    line_top[pulse_count]    = panel.rgb_top;
                    line_bottom[pulse_count] = panel.rgb_bottom;
                end
                pulse_count++;
            end
            if (panel.row_latch) begin
                latch_plane = latch_count % PLANE_COUNT;
                check_cycles("clk_pixel pulses before row_latch", pulse_count, PANEL_WIDTH);
                if (latch_count > 0) begin
                    check_cycles("output_enable_n low cycles", oe_cycles,
                                 DISPLAY_BASE_TICKS << last_plane);
                end
                check_row("row_address", panel.row_address, expected_row);
                for (int c = 0; c < PANEL_WIDTH; c++) begin
                    frame_top[panel.row_address][latch_plane][c]    = line_top[c];
                    frame_bottom[panel.row_address][latch_plane][c] = line_bottom[c];
                end
                if (latch_plane == PLANE_COUNT - 1) expected_row++; // wraps after row 7
                last_plane  = latch_plane;
                pulse_count = 0;
                oe_cycles   = 0;
                latch_count++;
                if (latch_plane == PLANE_COUNT - 1 &&
                    panel.row_address == ROW_BITS'(PANEL_HALF_HEIGHT - 1)) begin
                    frame_count++;
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0] rec;
        bit          synced;
        rst_n     = 1'b0;
        serial_rx = 1'b1;
        $readmemh("tb/hub75_vectors.txt", vectors);
        bytes_total  = 0;
        checks_total = 0;
        vector_count = 0;
        while (vector_count < 128 &&
               (vectors[vector_count][31:28] === 4'h1 ||
                vectors[vector_count][31:28] === 4'h2)) begin
            if (vectors[vector_count][31:28] === 4'h1) bytes_total++;
            else checks_total++;
            vector_count++;
        end
        frame_cycles = PANEL_HALF_HEIGHT * (PLANE_COUNT * (2 * PANEL_WIDTH + 1) +
                       DISPLAY_BASE_TICKS * ((1 << PLANE_COUNT) - 1));
        cycle_limit  = 2 * (bytes_total * 10 * UART_TICKS_PER_BIT +
                       (checks_total + 2) * frame_cycles);
        if (vector_count == 0) report_failure("no records found in the vector file");
        repeat (10) @(posedge clk_in);
        rst_n <= 1'b1;
        synced = 1'b0;
        for (int i = 0; i < vector_count; i++) begin
            rec = vectors[i];
            if (rec[31:28] == 4'h1) begin
                send_byte(rec[7:0], rec[8]);
                synced = 1'b0;
            end else begin
                if (!synced) begin
                    wait_fresh_frame();
                    synced = 1'b1;
                end
                check_pixel(rec);
            end
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: tb/hub75_vectors.txt
// byte record 10000SDD: DD is the uart data byte, S=1 sends a low stop bit
// check record 2RPCCTB0: row, plane, column, expected rgb_top, expected rgb_bottom
// rgb nibbles of a check hold {r,g,b} with r as bit 2
// top (x 5, y 3) and bottom (x 5, y 11)
10000050 10000005 10000003 100000A5 10000003
10000050 10000005 1000000B 1000000F 10000000
// column 31 of row 0 in both halves
10000050 1000001F 10000000 100000F0 1000000F
10000050 1000001F 10000008 10000096 1000000C
// every plane at (5,3), bottom write leaves the top pixel alone
23005320 23105520 23205220 23305420
2001F540 2011F520 2021F530 2031F550
// brightness mask 0101, planes 1 and 3 dark
10000042 10000005
23005320 23105000 23205220 23305000
// all planes back on, then green disabled
10000042 1000000F
10000045 10000005
23005100 23105500 23205000 23305400
// all channels back on
10000045 10000007
// bottom (x 10, y 14) written normally
10000050 1000000A 1000000E 10000081 10000007
// unknown opcode, then a pixel opcode with a bad stop bit
10000011 10000150
// top (x 10, y 6) must still decode from its own opcode
10000050 1000000A 10000006 1000003C 10000009
2600A530 2610A410 2620A210 2630A340
